// ==== flist.f ====
+incdir+test
hdl/fp_add_pkg.sv
hdl/fp_leading_zero_count.sv
hdl/fp_operand_classify.sv
hdl/fp_significand_align.sv
hdl/fp_significand_add.sv
hdl/fp_normalize.sv
hdl/fp_adder_top.sv
test/fp_adder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fp_adder_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/fp_adder_model.svh ====
`ifndef FP_ADDER_MODEL_SVH
`define FP_ADDER_MODEL_SVH

// One accepted sample with the outputs the DUT owes for it
typedef struct {
    string       name;          // Operand category, printed on a mismatch
    float32_t    a;
    float32_t    b;
    fp_op_e      op;
    logic [31:0] result;
    logic        invalid;
    logic        overflow;
    logic        underflow;
} expect_t;

// Zeros above the top set bit of a 24-bit significand, 24 when it is zero
function automatic int leading_zeros(logic [23:0] sig);
    int n;
    n = 0;
    while ((n < 24) && !sig[23]) begin
        sig = sig << 1;
        n++;
    end
    return n;
endfunction

// Fills in the result and flags of e from its operands and opcode
function automatic void compute_expected(inout expect_t e);
    float32_t    b_eff;                     // B with the opcode folded into its sign
    float32_t    maj;
    float32_t    mnr;
    logic        a_nan, b_nan, a_inf, b_inf;
    logic [24:0] maj_sig;
    logic [24:0] mnr_sig;
    logic [24:0] sum;                       // Bit 24 is the carry
    int          diff;
    int          exp_r;
    int          lz;
    b_eff      = e.b;
    b_eff.sign = e.b.sign ^ (e.op == FP_SUB);
    a_nan = (e.a.exponent == 8'hFF) && (e.a.fraction != 23'd0);
    b_nan = (e.b.exponent == 8'hFF) && (e.b.fraction != 23'd0);
    a_inf = (e.a.exponent == 8'hFF) && (e.a.fraction == 23'd0);
    b_inf = (e.b.exponent == 8'hFF) && (e.b.fraction == 23'd0);
    e.result    = 32'd0;
    e.invalid   = 1'b0;
    e.overflow  = 1'b0;
    e.underflow = 1'b0;
    // Any NaN, or infinities pulling in opposite directions
    if (a_nan || b_nan || (a_inf && b_inf && (e.a.sign != b_eff.sign))) begin
        e.result  = CANONICAL_NAN;
        e.invalid = 1'b1;
        return;
    end
    if (a_inf || b_inf) begin
        e.result = a_inf ? {e.a.sign, 8'hFF, 23'd0} : {b_eff.sign, 8'hFF, 23'd0};
        return;
    end
    // Larger exponent wins, a tie goes to A unless B' has the larger fraction
    if ((e.a.exponent > b_eff.exponent) ||
        ((e.a.exponent == b_eff.exponent) && (e.a.fraction >= b_eff.fraction))) begin
        maj = e.a;
        mnr = b_eff;
    end else begin
        maj = b_eff;
        mnr = e.a;
    end
    maj_sig = {1'b0, maj.exponent != 8'd0, maj.fraction};  // Hidden bit only for a non-zero exponent
    mnr_sig = {1'b0, mnr.exponent != 8'd0, mnr.fraction};
    diff    = int'(maj.exponent) - int'(mnr.exponent);
    mnr_sig = (diff >= 24) ? 25'd0 : (mnr_sig >> diff);   // Truncating alignment
    sum     = (maj.sign == mnr.sign) ? (maj_sig + mnr_sig) : (maj_sig - mnr_sig);
    exp_r   = int'(maj.exponent);
    if (sum[24]) begin
        sum   = sum >> 1;
        exp_r = exp_r + 1;
        if (exp_r == 255) begin
            e.result   = {maj.sign, 8'hFF, 23'd0};
            e.overflow = 1'b1;
            return;
        end
    end else if (sum == 25'd0) begin
        return;                                 // Exact zero stays +0
    end else begin
        lz = leading_zeros(sum[23:0]);
        if ((lz != 0) && (lz < exp_r)) begin
            sum   = sum << lz;
            exp_r = exp_r - lz;
        end else if (lz != 0) begin
            // Leading one is out of reach, so the result goes subnormal
            if (exp_r != 0) begin
                sum = sum << (exp_r - 1);
            end
            exp_r       = 0;
            e.underflow = 1'b1;
        end
    end
    e.result = {maj.sign, 8'(exp_r), sum[22:0]};
endfunction

`endif

// ==== test/fp_adder_tb.sv ====
`timescale 1ns/10ps

module fp_adder_tb;
    import fp_add_pkg::*;

    `include "fp_adder_model.svh"

    localparam logic [31:0] SEED         = 32'h847c824e;
    localparam int unsigned N_CYCLES     = 3000;   // Stimulus cycles after reset
    localparam int unsigned DRAIN_CYCLES = 64;     // Far more than four stages need
    localparam int unsigned TIMEOUT_NS   = N_CYCLES * 40 + 2000;
    localparam int unsigned LATENCY      = 4;      // Enabled edges from input to output

    logic     clk_i = 1'b0;
    logic     rst_n_i;
    logic     clk_en_i;
    logic     valid_i;
    fp_op_e   op_i;
    float32_t operand_a_i;
    float32_t operand_b_i;
    logic     valid_o;
    float32_t result_o;
    logic     invalid_o;
    logic     overflow_o;
    logic     underflow_o;

    string       stim_name;        // Category of the sample now on the inputs
    expect_t     exp_q[$];         // Expected results in input order
    int unsigned accept_q[$];      // Enabled-edge index at which each input was taken
    int unsigned enabled_edges;    // Edges out of reset with clk_en_i high
    int unsigned mismatch_errors;
    int unsigned other_errors;
    int unsigned accepted_count;
    int unsigned produced_count;   // Fresh valid_o pulses
    bit          checking;         // Set once the first reset edge has passed
    bit          last_rst_n;
    bit          last_en;
    logic [35:0] held_out;         // Outputs seen at the previous edge

    always #10 clk_i = ~clk_i;

    fp_adder_top dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

    // Picks an operand category and two operands that exercise it
    task automatic draw_operands(output float32_t a, output float32_t b, output string name);
        int unsigned kind;
        int unsigned which;
        kind       = $urandom_range(9);
        which      = $urandom_range(3);
        a          = $urandom;
        b          = $urandom;
        a.exponent = 8'($urandom_range(254, 1));   // Finite normals unless changed below
        b.exponent = 8'($urandom_range(254, 1));
        case (kind)
            0: name = "random_normal";
            1: begin
                name       = "same_exponent";
                b.exponent = a.exponent;
            end
            2: begin
                name = "close_exponent";
                if (a.exponent > 8'd24) begin
                    b.exponent = a.exponent - 8'($urandom_range(24));
                end
            end
            3: begin
                name       = "near_equal";
                b          = a;
                b.fraction = a.fraction ^ 23'($urandom_range(3));  // Zero delta cancels exactly
            end
            4: begin
                name       = "small_exponent";
                a.exponent = 8'($urandom_range(2));
                b          = a;
                b.fraction = a.fraction ^ 23'($urandom_range(255));
            end
            5: begin
                name       = "large_exponent";           // Same-sign sums here tend to overflow
                a.exponent = 8'($urandom_range(254, 250));
                b.exponent = 8'($urandom_range(254, 250));
            end
            6: begin
                name = "zero";
                a    = {a.sign, 31'd0};
                if (which >= 2) begin
                    b = {b.sign, 31'd0};
                end
            end
            7: begin
                name = "nan";
                if (which[0]) begin
                    a.exponent    = 8'hFF;
                    a.fraction[0] = 1'b1;                // Keeps the fraction non-zero
                end else begin
                    b.exponent    = 8'hFF;
                    b.fraction[0] = 1'b1;
                end
            end
            8: begin
                name = "infinity";
                // Either operand or both so that inf minus inf shows up too
                if (which != 1) begin
                    a = {a.sign, 8'hFF, 23'd0};
                end
                if (which != 0) begin
                    b = {b.sign, 8'hFF, 23'd0};
                end
            end
            default: begin
                name       = "subnormal";
                a.exponent = 8'd0;
                b.exponent = 8'd0;
            end
        endcase
    endtask

    // Compares the output register with the oldest expected entry
    task automatic check_result(input expect_t e);
        assert (result_o == e.result) else begin
            mismatch_errors++;
            $display("mismatch %s result for %h %s %h: expected %h actual %h",
                     e.name, e.a, (e.op == FP_SUB) ? "-" : "+", e.b, e.result, result_o);
        end
        assert ({invalid_o, overflow_o, underflow_o} == {e.invalid, e.overflow, e.underflow})
        else begin
            mismatch_errors++;
            $display("mismatch %s flags ivu for %h %s %h: expected %b%b%b actual %b%b%b",
                     e.name, e.a, (e.op == FP_SUB) ? "-" : "+", e.b,
                     e.invalid, e.overflow, e.underflow, invalid_o, overflow_o, underflow_o);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if ((mismatch_errors == 0) && (other_errors == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // Reads outputs registered at the previous edge and inputs sampled at this one
    always @(posedge clk_i) begin : monitor
        expect_t     e;
        int unsigned accepted_at;
        int unsigned latency;
        if (checking) begin
            if (last_rst_n && !last_en) begin
                assert ({valid_o, result_o, invalid_o, overflow_o, underflow_o} == held_out)
                else begin
                    other_errors++;
                    $display("outputs changed on an edge where clk_en_i was low");
                end
            end else if (last_rst_n && valid_o) begin
                produced_count++;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("valid_o was high with no accepted input in flight");
                end else begin
                    e           = exp_q.pop_front();
                    accepted_at = accept_q.pop_front();
                    check_result(e);
                    // Accepting edge and output edge both count
                    latency = enabled_edges - accepted_at + 1;
                    assert (latency == LATENCY) else begin
                        mismatch_errors++;
                        $display("mismatch %s latency in enabled edges: expected %0d actual %0d",
                                 e.name, LATENCY, latency);
                    end
                end
            end
            // Idle slots carry 0 + 0 and reset clears the output register
            if (!valid_o) begin
                assert ({result_o, invalid_o, overflow_o, underflow_o} == 35'd0) else begin
                    mismatch_errors++;
                    $display("mismatch idle_output: expected %h actual %h", 35'd0,
                             {result_o, invalid_o, overflow_o, underflow_o});
                end
            end
        end
        held_out   = {valid_o, result_o, invalid_o, overflow_o, underflow_o};
        last_rst_n = rst_n_i;
        last_en    = clk_en_i;
        checking   = 1'b1;                   // First edge is always inside reset
        if (rst_n_i && clk_en_i) begin
            enabled_edges++;
        end
        if (rst_n_i && clk_en_i && valid_i) begin
            e.name = stim_name;
            e.a    = operand_a_i;
            e.b    = operand_b_i;
            e.op   = op_i;
            compute_expected(e);
            exp_q.push_back(e);
            accept_q.push_back(enabled_edges);
            accepted_count++;
        end
    end

    initial begin : stimulus
        float32_t    a;
        float32_t    b;
        string       name;
        int unsigned waited;
        void'($urandom(SEED));
        rst_n_i     = 1'b0;
        clk_en_i    = 1'b1;                  // Stages fill with zero data during reset
        valid_i     = 1'b0;
        op_i        = FP_ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        stim_name   = "idle";
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(posedge clk_i);
            clk_en_i <= ($urandom_range(99) < 80);
            if ($urandom_range(99) < 70) begin
                draw_operands(a, b, name);
                valid_i     <= 1'b1;
                op_i        <= ($urandom_range(1) == 1) ? FP_SUB : FP_ADD;
                operand_a_i <= a;
                operand_b_i <= b;
                stim_name   <= name;
            end else begin
                valid_i     <= 1'b0;         // Idle slots keep zero operands
                op_i        <= FP_ADD;
                operand_a_i <= '0;
                operand_b_i <= '0;
                stim_name   <= "idle";
            end
        end
        @(posedge clk_i);
        clk_en_i    <= 1'b1;
        valid_i     <= 1'b0;
        op_i        <= FP_ADD;
        operand_a_i <= '0;
        operand_b_i <= '0;
        // Queue is looked at on falling edges once the monitor has run
        waited = 0;
        @(negedge clk_i);
        while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
            @(negedge clk_i);
            waited++;
        end
        repeat (4) @(negedge clk_i);         // A stray valid_o would show up here
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("%0d expected results never came out of the DUT", exp_q.size());
        end
        assert (produced_count == accepted_count) else begin
            other_errors++;
            $display("%0d inputs accepted but %0d valid outputs seen",
                     accepted_count, produced_count);
        end
        finish_run();
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        other_errors++;
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        finish_run();
    end

endmodule : fp_adder_tb

// ==== hdl/fp_adder_top.sv ====
`timescale 1ns/10ps

module fp_adder_top #(
    parameter int SIG_WIDTH = fp_add_pkg::SIG_W        // Width seen by the leading-zero counter
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 clk_en_i,               // Low freezes every stage
    input  logic                 valid_i,
    input  fp_add_pkg::fp_op_e   op_i,
    input  fp_add_pkg::float32_t operand_a_i,
    input  fp_add_pkg::float32_t operand_b_i,
    output logic                 valid_o,
    output fp_add_pkg::float32_t result_o,
    output logic                 invalid_o,
    output logic                 overflow_o,
    output logic                 underflow_o
);
    import fp_add_pkg::*;

    cmp_stage_t   cmp_stage;            // Operands ordered, specials classified
    align_stage_t align_stage;          // Minor significand aligned
    sum_stage_t   sum_stage;            // Raw significand sum

    fp_operand_classify classify_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .stage_o     (cmp_stage)
    );

    fp_significand_align align_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .stage_i  (cmp_stage),
        .stage_o  (align_stage)
    );

    fp_significand_add add_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .stage_i  (align_stage),
        .stage_o  (sum_stage)
    );

    // Last stage drives the ports directly from its output register
    fp_normalize #(
        .SIG_WIDTH   (SIG_WIDTH)
    ) normalize_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clk_en_i    (clk_en_i),
        .stage_i     (sum_stage),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o)
    );

endmodule : fp_adder_top

// ==== hdl/fp_normalize.sv ====
`timescale 1ns/10ps

module fp_normalize #(
    parameter int SIG_WIDTH = 24
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   clk_en_i,
    input  fp_add_pkg::sum_stage_t stage_i,
    output logic                   valid_o,
    output fp_add_pkg::float32_t   result_o,
    output logic                   invalid_o,
    output logic                   overflow_o,
    output logic                   underflow_o
);
    import fp_add_pkg::*;

    localparam int CNT_W = $clog2(SIG_WIDTH + 1);

    logic [SIG_WIDTH-1:0] sum_sig;      // Sum without the carry bit
    logic                 carry;
    logic [CNT_W-1:0]     lz_count;
    logic [EXP_W-1:0]     lz_ext;       // Leading zeros at exponent width for compares
    logic [EXP_W-1:0]     exp_inc;
    logic [SIG_WIDTH-1:0] norm_sig;
    float32_t             result_d;
    logic                 invalid_d, overflow_d, underflow_d;

    assign sum_sig = stage_i.sum[SIG_WIDTH-1:0];
    assign carry   = stage_i.sum[SIG_WIDTH];
    assign exp_inc = stage_i.exponent + 1'b1;
    assign lz_ext  = EXP_W'(lz_count);

    fp_leading_zero_count #(
        .WIDTH   (SIG_WIDTH)
    ) lzc_i (
        .value_i (sum_sig),
        .count_o (lz_count)
    );

    always_comb begin
        norm_sig    = sum_sig;
        result_d    = {stage_i.sign, stage_i.exponent, sum_sig[FRAC_W-1:0]};
        invalid_d   = 1'b0;
        overflow_d  = 1'b0;
        underflow_d = 1'b0;

        if (stage_i.special == SPEC_NAN) begin
            result_d  = CANONICAL_NAN;
            invalid_d = 1'b1;
        end else if (stage_i.special == SPEC_INF) begin
            result_d = {stage_i.spec_sign, EXP_MAX, {FRAC_W{1'b0}}};   // No flag for a true infinity
        end else if (carry) begin
            // Carry out means the sum is one position too wide so it moves right
            norm_sig = stage_i.sum[SIG_WIDTH:1];
            if (exp_inc == EXP_MAX) begin
                result_d   = {stage_i.sign, EXP_MAX, {FRAC_W{1'b0}}};
                overflow_d = 1'b1;
            end else begin
                result_d = {stage_i.sign, exp_inc, norm_sig[FRAC_W-1:0]};
            end
        end else if (sum_sig == '0) begin
            result_d = '0;                      // Exact cancellation is positive zero
        end else if ((lz_count != '0) && (lz_ext < stage_i.exponent)) begin
            norm_sig = sum_sig << lz_count;
            result_d = {stage_i.sign, stage_i.exponent - lz_ext, norm_sig[FRAC_W-1:0]};
        end else if (lz_count != '0) begin
            // The leading one is out of reach so the result goes subnormal
            if (stage_i.exponent != '0) begin
                norm_sig = sum_sig << (stage_i.exponent - 1'b1);
            end
            result_d    = {stage_i.sign, {EXP_W{1'b0}}, norm_sig[FRAC_W-1:0]};
            underflow_d = 1'b1;
        end
    end

    // Output register holds its value while clk_en_i is low
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o     <= 1'b0;
            result_o    <= '0;
            invalid_o   <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else if (clk_en_i) begin
            valid_o     <= stage_i.valid;
            result_o    <= result_d;
            invalid_o   <= invalid_d;
            overflow_o  <= overflow_d;
            underflow_o <= underflow_d;
        end
    end

endmodule : fp_normalize

// ==== hdl/fp_significand_add.sv ====
`timescale 1ns/10ps

module fp_significand_add (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     clk_en_i,
    input  fp_add_pkg::align_stage_t stage_i,
    output fp_add_pkg::sum_stage_t   stage_o
);
    import fp_add_pkg::*;

    logic [SIG_W-1:0] major_sig;        // Major fraction with its hidden bit
    logic [SIG_W:0]   sum;              // One bit wider to catch the carry
    sum_stage_t       stage_d;

    // Hidden bit is set for a normal exponent only
    assign major_sig = {stage_i.major.exponent != '0, stage_i.major.fraction};

    // The major magnitude is never below the aligned minor, so no borrow can leave the MSB
    always_comb begin
        if (stage_i.eff_sub) begin
            sum = {1'b0, major_sig} - {1'b0, stage_i.minor_sig};
        end else begin
            sum = {1'b0, major_sig} + {1'b0, stage_i.minor_sig};
        end
    end

    always_comb begin
        stage_d.valid    = stage_i.valid;
        stage_d.sign     = stage_i.major.sign;     // Magnitude arithmetic keeps the major sign
        stage_d.exponent = stage_i.major.exponent;
        stage_d.sum      = sum;
        stage_d.special   = stage_i.special;
        stage_d.spec_sign = stage_i.spec_sign;
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule : fp_significand_add

// ==== hdl/fp_significand_align.sv ====
`timescale 1ns/10ps

module fp_significand_align (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     clk_en_i,
    input  fp_add_pkg::cmp_stage_t   stage_i,
    output fp_add_pkg::align_stage_t stage_o
);
    import fp_add_pkg::*;

    logic [SIG_W-1:0] aligned_sig;      // Minor significand at the major's weight
    logic             shift_out;        // Every minor bit falls off the bottom
    align_stage_t     stage_d;

    // A difference of SIG_W or more leaves nothing of the minor operand
    assign shift_out = (stage_i.shift >= EXP_W'(SIG_W));

    // Bits shifted below the LSB are simply dropped
    assign aligned_sig = shift_out ? '0 : (stage_i.minor_sig >> stage_i.shift);

    always_comb begin
        stage_d.valid     = stage_i.valid;
        stage_d.major     = stage_i.major;
        stage_d.minor_sig = aligned_sig;

        // Differing signs turn the operation into a magnitude subtraction
        stage_d.eff_sub = stage_i.major.sign ^ stage_i.minor_sign;

        stage_d.special   = stage_i.special;       // Special results ride along untouched
        stage_d.spec_sign = stage_i.spec_sign;
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;                 // Empty pipeline slot after reset
        end
    end

endmodule : fp_significand_align

// ==== hdl/fp_operand_classify.sv ====
`timescale 1ns/10ps

module fp_operand_classify (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   clk_en_i,
    input  logic                   valid_i,
    input  fp_add_pkg::fp_op_e     op_i,
    input  fp_add_pkg::float32_t   operand_a_i,
    input  fp_add_pkg::float32_t   operand_b_i,
    output fp_add_pkg::cmp_stage_t stage_o
);
    import fp_add_pkg::*;

    float32_t   op_b;                   // B with the subtraction folded into its sign
    logic       a_is_nan, b_is_nan;
    logic       a_is_inf, b_is_inf;
    logic [EXP_W:0] exp_diff;           // Extra top bit is the borrow of A minus B
    float32_t   major, minor;
    cmp_stage_t stage_d;

    // A subtraction is an addition with B negated
    always_comb begin
        op_b      = operand_b_i;
        op_b.sign = operand_b_i.sign ^ (op_i == FP_SUB);
    end

    // All-ones exponent marks infinity when the fraction is clear, NaN otherwise
    assign a_is_nan = (operand_a_i.exponent == EXP_MAX) && (operand_a_i.fraction != '0);
    assign b_is_nan = (operand_b_i.exponent == EXP_MAX) && (operand_b_i.fraction != '0);
    assign a_is_inf = (operand_a_i.exponent == EXP_MAX) && (operand_a_i.fraction == '0);
    assign b_is_inf = (operand_b_i.exponent == EXP_MAX) && (operand_b_i.fraction == '0);

    assign exp_diff = {1'b0, operand_a_i.exponent} - {1'b0, op_b.exponent};

    always_comb begin
        stage_d.valid = valid_i;

        // Larger exponent wins and equal exponents fall back to the fraction
        if (exp_diff[EXP_W]) begin
            major         = op_b;
            minor         = operand_a_i;
            stage_d.shift = op_b.exponent - operand_a_i.exponent;
        end else begin
            if ((exp_diff == '0) && (operand_a_i.fraction < op_b.fraction)) begin
                major = op_b;
                minor = operand_a_i;
            end else begin
                major = operand_a_i;           // A also wins a full tie
                minor = op_b;
            end
            stage_d.shift = exp_diff[EXP_W-1:0];
        end

        stage_d.major      = major;
        stage_d.minor_sign = minor.sign;
        stage_d.minor_sig  = {minor.exponent != '0, minor.fraction};  // Hidden bit only if normal

        // NaN takes priority over infinity and opposite infinities are invalid
        stage_d.special   = SPEC_NONE;
        stage_d.spec_sign = 1'b0;
        if (a_is_nan || b_is_nan || (a_is_inf && b_is_inf && (operand_a_i.sign != op_b.sign))) begin
            stage_d.special = SPEC_NAN;
        end else if (a_is_inf) begin
            stage_d.special   = SPEC_INF;
            stage_d.spec_sign = operand_a_i.sign;
        end else if (b_is_inf) begin
            stage_d.special   = SPEC_INF;
            stage_d.spec_sign = op_b.sign;     // Subtracting an infinity flips it
        end
    end

    // Stage register holds its value while clk_en_i is low
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule : fp_operand_classify

// ==== hdl/fp_leading_zero_count.sv ====
`timescale 1ns/10ps

module fp_leading_zero_count #(
    parameter int WIDTH = 24
) (
    input  logic [WIDTH-1:0]             value_i,
    output logic [$clog2(WIDTH+1)-1:0]   count_o
);

    // Wide enough to hold WIDTH itself for an all-zero input
    localparam int CNT_W = $clog2(WIDTH + 1);

    // Scan upward so the highest set bit is the last one written
    always_comb begin
        count_o = CNT_W'(WIDTH);                    // Nothing set means every bit is a zero
        for (int i = 0; i < WIDTH; i++) begin
            if (value_i[i]) begin
                count_o = CNT_W'(WIDTH - 1 - i);   // Zeros sitting above bit i
            end
        end
    end

endmodule : fp_leading_zero_count

// ==== hdl/fp_add_pkg.sv ====
package fp_add_pkg;

    // Binary32 field widths
    localparam int unsigned EXP_W  = 8;
    localparam int unsigned FRAC_W = 23;
    localparam int unsigned SIG_W  = FRAC_W + 1;      // Fraction plus the hidden bit

    localparam logic [EXP_W-1:0] EXP_MAX = 8'hFF;      // Exponent of infinities and NaNs

    // Quiet NaN returned for every invalid operation
    localparam logic [31:0] CANONICAL_NAN = 32'h7FC00000;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [FRAC_W-1:0] fraction;
    } float32_t;

    // Operation applied to the operand pair
    typedef enum logic {
        FP_ADD = 1'b0,
        FP_SUB = 1'b1
    } fp_op_e;

    // Result kinds that bypass the datapath
    typedef enum logic [1:0] {
        SPEC_NONE = 2'd0,
        SPEC_NAN  = 2'd1,
        SPEC_INF  = 2'd2
    } special_e;

    // Classification and swap stage
    typedef struct packed {
        logic             valid;
        float32_t         major;         // Larger operand, sign already folded for B
        logic             minor_sign;
        logic [SIG_W-1:0] minor_sig;     // Hidden bit and fraction of the smaller operand
        logic [EXP_W-1:0] shift;         // Absolute exponent difference
        special_e         special;
        logic             spec_sign;     // Sign of an infinity result
    } cmp_stage_t;

    // Alignment stage
    typedef struct packed {
        logic             valid;
        float32_t         major;
        logic             eff_sub;       // Signs differ so magnitudes are subtracted
        logic [SIG_W-1:0] minor_sig;     // Minor significand after the right shift
        special_e         special;
        logic             spec_sign;
    } align_stage_t;

    // Significand sum stage
    typedef struct packed {
        logic             valid;
        logic             sign;          // Always the sign of the major operand
        logic [EXP_W-1:0] exponent;
        logic [SIG_W:0]   sum;           // MSB is the carry out of the addition
        special_e         special;
        logic             spec_sign;
    } sum_stage_t;

endpackage : fp_add_pkg
